/* verilog/sram_alloc_pkg.sv */
`default_nettype none

package sram_alloc_pkg;

    // ************************************************************
    // switch geometry
    // ************************************************************
    localparam int NUM_SRAM = 32;
    localparam int NUM_PORT = 16;

    localparam int SRAM_W   = $clog2(NUM_SRAM);
    localparam int PORT_W   = $clog2(NUM_PORT);
    localparam int SPACE_W  = 11;
    localparam int LEN_W    = 9;
    localparam int AMOUNT_W = 9;
    localparam int THRESH_W = 6;

    typedef logic [SRAM_W-1:0]   sram_idx_t;
    typedef logic [PORT_W-1:0]   port_idx_t;
    typedef logic [SPACE_W-1:0]  space_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [AMOUNT_W-1:0] amount_t;
    typedef logic [THRESH_W-1:0] thresh_t;

    // ************************************************************
    // match modes and their scan limits
    // ************************************************************
    typedef enum logic [1:0] {
        MODE_STATIC  = 2'd0,
        MODE_SEMI    = 2'd1,
        MODE_DYNAMIC = 2'd2
    } match_mode_t;

    // each limit equals the length of the mode's bank list
    localparam thresh_t MAX_STATIC  = 6'd1;
    localparam thresh_t MAX_SEMI    = 6'd17;
    localparam thresh_t MAX_DYNAMIC = 6'd32;

    localparam space_t SPACE_INIT = 11'd2047;

endpackage

`default_nettype wire

/* verilog/sram_scan_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface sram_scan_if
    import sram_alloc_pkg::*;
();
    // candidate issued by the sequencer
    logic      cand_valid;
    sram_idx_t cand_sram;
    logic      cand_fast;
    logic      cand_last;

    // status of that candidate, one cycle later
    logic      stat_valid;
    sram_idx_t stat_sram;
    logic      stat_fast;
    logic      stat_last;
    space_t    stat_free;
    logic      stat_occupied;
    amount_t   stat_amount;

    modport seq (output cand_valid, cand_sram, cand_fast, cand_last);

    modport tbl (
        input  cand_valid, cand_sram, cand_fast, cand_last,
        output stat_valid, stat_sram, stat_fast, stat_last,
        output stat_free, stat_occupied, stat_amount
    );

    modport picker (
        input stat_valid, stat_sram, stat_fast, stat_last,
        input stat_free, stat_occupied, stat_amount
    );

endinterface

`default_nettype wire

/* verilog/sram_scan_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_scan_sequencer
    import sram_alloc_pkg::*;
#(
    parameter int PORT_IDX = 3
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        req,
    input  port_idx_t        dest_port,
    input  len_t             length,
    input  match_mode_t      match_mode,
    input  wire logic [4:0]  threshold,
    input  wire logic        scan_done,
    input  wire logic        match_ok,
    input  sram_idx_t        matched_sram,
    output logic             busy,
    output port_idx_t        cur_port,
    output len_t             cur_len,
    output thresh_t          eff_threshold,
    output logic             last_valid,
    output sram_idx_t        last_sram,
    output port_idx_t        last_port,
    sram_scan_if.seq         scan
);

    localparam sram_idx_t FIRST_SRAM = sram_idx_t'(PORT_IDX);

    match_mode_t cur_mode;
    sram_idx_t   next_sram;
    logic        fast_ok;

    function automatic thresh_t mode_max(input match_mode_t mode);
        case (mode)
            MODE_STATIC: return MAX_STATIC;
            MODE_SEMI:   return MAX_SEMI;
            default:     return MAX_DYNAMIC;
        endcase
    endfunction

    // bank following cur in the visiting order of the mode
    function automatic sram_idx_t next_bank(input sram_idx_t cur, input match_mode_t mode);
        case (mode)
            MODE_STATIC: return FIRST_SRAM;
            MODE_SEMI:   begin
                if (cur == 5'd31) begin
                    return FIRST_SRAM;
                end else if (cur < 5'd16) begin
                    return 5'd16;
                end
                return cur + 5'd1;
            end
            default:     return cur + 5'd1;
        endcase
    endfunction

    function automatic logic is_last(input sram_idx_t b, input match_mode_t mode);
        case (mode)
            MODE_STATIC: return 1'b1;
            MODE_SEMI:   return b == 5'd31;
            default:     return sram_idx_t'(b + 5'd1) == FIRST_SRAM;
        endcase
    endfunction

    // a fast candidate is always followed by the first bank of the mode
    assign next_sram = scan.cand_fast ? FIRST_SRAM : next_bank(scan.cand_sram, cur_mode);
    assign fast_ok   = last_valid && (last_port == dest_port);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy            <= 1'b0;
            scan.cand_valid <= 1'b0;
            last_valid      <= 1'b0;
        end else if (!busy) begin
            if (req) begin
                busy            <= 1'b1;
                scan.cand_valid <= 1'b1;
            end
        end else if (scan_done) begin
            busy            <= 1'b0;
            scan.cand_valid <= 1'b0;
            if (match_ok) begin
                last_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req) begin
            cur_port      <= dest_port;
            cur_len       <= length;
            cur_mode      <= match_mode;
            eff_threshold <= ({1'b0, threshold} > mode_max(match_mode)) ?
                             mode_max(match_mode) : {1'b0, threshold};
            if (fast_ok) begin
                scan.cand_sram <= last_sram;
                scan.cand_fast <= 1'b1;
                scan.cand_last <= 1'b0;
            end else begin
                scan.cand_sram <= FIRST_SRAM;
                scan.cand_fast <= 1'b0;
                scan.cand_last <= is_last(FIRST_SRAM, match_mode);
            end
        end else if (busy && !scan_done) begin
            scan.cand_sram <= next_sram;
            scan.cand_fast <= 1'b0;
            scan.cand_last <= is_last(next_sram, cur_mode);
        end
        if (busy && scan_done && match_ok) begin
            last_sram <= matched_sram;
            last_port <= cur_port;
        end
    end

endmodule

`default_nettype wire

/* verilog/sram_status_table.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_status_table
    import sram_alloc_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  port_idx_t                cur_port,
    input  wire logic [NUM_SRAM-1:0] occupied,
    input  wire logic                commit,
    input  sram_idx_t                commit_sram,
    input  port_idx_t                commit_port,
    input  len_t                     commit_len,
    input  wire logic                release_valid,
    input  sram_idx_t                release_sram,
    input  port_idx_t                release_port,
    input  len_t                     release_len,
    sram_scan_if.tbl                 scan
);

    // ************************************************************
    // bank bookkeeping
    // ************************************************************
    space_t  free_space  [NUM_SRAM];
    amount_t amount      [NUM_SRAM][NUM_PORT];
    space_t  free_next   [NUM_SRAM];
    amount_t amount_next [NUM_SRAM][NUM_PORT];

    // commit and release to one bank in the same cycle both take effect
    always_comb begin
        free_next   = free_space;
        amount_next = amount;
        if (commit) begin
            free_next[commit_sram] = free_next[commit_sram] - {2'b00, commit_len};
            amount_next[commit_sram][commit_port] =
                amount_next[commit_sram][commit_port] + 9'd1;
        end
        if (release_valid) begin
            free_next[release_sram] = free_next[release_sram] + {2'b00, release_len};
            amount_next[release_sram][release_port] =
                amount_next[release_sram][release_port] - 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SRAM; i++) begin
                free_space[i] <= SPACE_INIT;
                for (int p = 0; p < NUM_PORT; p++) begin
                    amount[i][p] <= '0;
                end
            end
        end else begin
            free_space <= free_next;
            amount     <= amount_next;
        end
    end

    // ************************************************************
    // status lookup for the current candidate
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan.stat_valid <= 1'b0;
        end else begin
            scan.stat_valid <= scan.cand_valid;
        end
    end

    always_ff @(posedge clk) begin
        scan.stat_sram     <= scan.cand_sram;
        scan.stat_fast     <= scan.cand_fast;
        scan.stat_last     <= scan.cand_last;
        scan.stat_free     <= free_space[scan.cand_sram];
        scan.stat_occupied <= occupied[scan.cand_sram];
        scan.stat_amount   <= amount[scan.cand_sram][cur_port];
    end

endmodule

`default_nettype wire

/* verilog/sram_best_picker.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_best_picker
    import sram_alloc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  port_idx_t  cur_port,
    input  len_t       cur_len,
    input  thresh_t    eff_threshold,
    sram_scan_if.picker scan,
    output logic       scan_done,
    output logic       match_end,
    output logic       match_ok,
    output sram_idx_t  matched_sram,
    output logic       commit,
    output sram_idx_t  commit_sram,
    output port_idx_t  commit_port,
    output len_t       commit_len
);

    // hold masks the candidates still in flight after a decision
    logic      hold;
    logic      find;
    thresh_t   eval_cnt;
    sram_idx_t best_sram;
    amount_t   best_amount;

    logic      live;
    logic      eligible;
    logic      take;
    logic      new_find;
    thresh_t   new_cnt;
    logic      fast_hit;
    logic      scan_hit;
    logic      scan_fail;
    logic      decide;
    sram_idx_t pick_sram;

    // ************************************************************
    // evaluation of one status beat
    // ************************************************************
    assign live     = scan.stat_valid && !hold;
    assign eligible = !scan.stat_occupied && (scan.stat_free >= {2'b00, cur_len});

    // first eligible bank wins unless a later one has strictly more packets
    assign take     = eligible && (!find || (scan.stat_amount > best_amount));
    assign new_find = find || eligible;
    assign new_cnt  = eval_cnt + 6'd1;

    assign fast_hit  = scan.stat_fast && eligible;
    assign scan_hit  = !scan.stat_fast && new_find && (new_cnt >= eff_threshold);
    assign scan_fail = !scan.stat_fast && scan.stat_last && !new_find;
    assign decide    = live && (fast_hit || scan_hit || scan_fail);
    assign pick_sram = (scan.stat_fast || take) ? scan.stat_sram : best_sram;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_end <= 1'b0;
            match_ok  <= 1'b0;
            hold      <= 1'b0;
            find      <= 1'b0;
            eval_cnt  <= '0;
        end else begin
            match_end <= decide;
            match_ok  <= decide && (fast_hit || scan_hit);
            if (decide) begin
                hold     <= 1'b1;
                find     <= 1'b0;
                eval_cnt <= '0;
            end else if (!scan.stat_valid) begin
                hold <= 1'b0;
            end else if (live && !scan.stat_fast) begin
                find     <= new_find;
                eval_cnt <= new_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (live && !scan.stat_fast && take) begin
            best_sram   <= scan.stat_sram;
            best_amount <= scan.stat_amount;
        end
        if (decide) begin
            matched_sram <= pick_sram;
            commit_port  <= cur_port;
            commit_len   <= cur_len;
        end
    end

    // the booking goes out together with a successful match_end
    assign scan_done   = match_end;
    assign commit      = match_ok;
    assign commit_sram = matched_sram;

endmodule

`default_nettype wire

/* verilog/port_wr_alloc.sv */
`timescale 1ns/100ps
`default_nettype none

module port_wr_alloc
    import sram_alloc_pkg::*;
#(
    parameter int PORT_IDX = 3
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req,
    input  port_idx_t                dest_port,
    input  len_t                     length,
    input  match_mode_t              match_mode,
    input  wire logic [4:0]          threshold,
    input  wire logic [NUM_SRAM-1:0] occupied,
    input  wire logic                release_valid,
    input  sram_idx_t                release_sram,
    input  port_idx_t                release_port,
    input  len_t                     release_len,
    output logic                     busy,
    output logic                     match_end,
    output logic                     match_ok,
    output sram_idx_t                matched_sram
);

    port_idx_t cur_port;
    len_t      cur_len;
    thresh_t   eff_threshold;
    logic      scan_done;
    logic      commit;
    sram_idx_t commit_sram;
    port_idx_t commit_port;
    len_t      commit_len;

    sram_scan_if scan_bus ();

    // ************************************************************
    // sequencer -> status table -> best picker
    // ************************************************************
    sram_scan_sequencer #(
        .PORT_IDX (PORT_IDX)
    ) i_sram_scan_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .dest_port     (dest_port),
        .length        (length),
        .match_mode    (match_mode),
        .threshold     (threshold),
        .scan_done     (scan_done),
        .match_ok      (match_ok),
        .matched_sram  (matched_sram),
        .busy          (busy),
        .cur_port      (cur_port),
        .cur_len       (cur_len),
        .eff_threshold (eff_threshold),
        .last_valid    (),
        .last_sram     (),
        .last_port     (),
        .scan          (scan_bus.seq)
    );

    sram_status_table i_sram_status_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .cur_port      (cur_port),
        .occupied      (occupied),
        .commit        (commit),
        .commit_sram   (commit_sram),
        .commit_port   (commit_port),
        .commit_len    (commit_len),
        .release_valid (release_valid),
        .release_sram  (release_sram),
        .release_port  (release_port),
        .release_len   (release_len),
        .scan          (scan_bus.tbl)
    );

    sram_best_picker i_sram_best_picker (
        .clk           (clk),
        .rst_n         (rst_n),
        .cur_port      (cur_port),
        .cur_len       (cur_len),
        .eff_threshold (eff_threshold),
        .scan          (scan_bus.picker),
        .scan_done     (scan_done),
        .match_end     (match_end),
        .match_ok      (match_ok),
        .matched_sram  (matched_sram),
        .commit        (commit),
        .commit_sram   (commit_sram),
        .commit_port   (commit_port),
        .commit_len    (commit_len)
    );

endmodule

`default_nettype wire

/* dv/tb_port_wr_alloc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_port_wr_alloc
    import sram_alloc_pkg::*;
#(
    parameter int PORT_IDX = 3
) ();

    localparam int NUM_TESTS  = 25;
    localparam int MAX_CYCLES = 80;

    typedef struct packed {
        match_mode_t         mode;
        logic [4:0]          thr;
        logic [NUM_SRAM-1:0] occ;
        port_idx_t           port;
        len_t                len;
        logic                dup;
        logic                rel;
        sram_idx_t           rel_sram;
        port_idx_t           rel_port;
        len_t                rel_len;
        logic                exp_ok;
        sram_idx_t           exp_sram;
        logic                exp_fast;
    } entry_t;

    logic                clk;
    logic                rst_n;
    logic                req;
    port_idx_t           dest_port;
    len_t                length;
    match_mode_t         match_mode;
    logic [4:0]          threshold;
    logic [NUM_SRAM-1:0] occupied;
    logic                release_valid;
    sram_idx_t           release_sram;
    port_idx_t           release_port;
    len_t                release_len;
    logic                busy;
    logic                match_end;
    logic                match_ok;
    sram_idx_t           matched_sram;

    entry_t      tests [NUM_TESTS];
    int          n_tests;
    int          errors;
    int          checks;
    int          end_cnt;
    logic [31:0] rng;

    // reference state of the bank table
    space_t      m_free [NUM_SRAM];
    amount_t     m_amt  [NUM_SRAM][NUM_PORT];
    logic        m_last_valid;
    sram_idx_t   m_last_sram;
    port_idx_t   m_last_port;

    port_wr_alloc #(
        .PORT_IDX (PORT_IDX)
    ) i_port_wr_alloc (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .dest_port     (dest_port),
        .length        (length),
        .match_mode    (match_mode),
        .threshold     (threshold),
        .occupied      (occupied),
        .release_valid (release_valid),
        .release_sram  (release_sram),
        .release_port  (release_port),
        .release_len   (release_len),
        .busy          (busy),
        .match_end     (match_end),
        .match_ok      (match_ok),
        .matched_sram  (matched_sram)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (match_end) begin
            end_cnt <= end_cnt + 1;
        end
    end

    initial begin
        #(NUM_TESTS * MAX_CYCLES * 20);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ************************************************************
    // reference model
    // ************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int list_len(input match_mode_t mode);
        case (mode)
            MODE_STATIC: return 1;
            MODE_SEMI:   return 17;
            default:     return NUM_SRAM;
        endcase
    endfunction

    // i-th bank visited by a scan in the given mode
    function automatic sram_idx_t list_bank(input match_mode_t mode, input int i);
        case (mode)
            MODE_STATIC: return sram_idx_t'(PORT_IDX);
            MODE_SEMI:   return (i == 0) ? sram_idx_t'(PORT_IDX) : sram_idx_t'(15 + i);
            default:     return sram_idx_t'((PORT_IDX + i) % NUM_SRAM);
        endcase
    endfunction

    task automatic predict(inout entry_t e);
        int        n;
        int        lim;
        int        cnt;
        logic      find;
        logic      done;
        logic      elig;
        sram_idx_t b;
        sram_idx_t best;
        amount_t   best_amt;
        n        = list_len(e.mode);
        lim      = (int'(e.thr) > n) ? n : int'(e.thr);
        cnt      = 0;
        find     = 1'b0;
        done     = 1'b0;
        best     = '0;
        best_amt = '0;
        if (e.rel) begin
            m_free[e.rel_sram] = m_free[e.rel_sram] + space_t'(e.rel_len);
            m_amt[e.rel_sram][e.rel_port] = m_amt[e.rel_sram][e.rel_port] - 9'd1;
        end
        e.exp_fast = m_last_valid && (m_last_port == e.port) && !e.occ[m_last_sram] &&
                     (m_free[m_last_sram] >= space_t'(e.len));
        if (e.exp_fast) begin
            best = m_last_sram;
            done = 1'b1;
        end else begin
            for (int i = 0; i < n && !done; i++) begin
                b    = list_bank(e.mode, i);
                elig = !e.occ[b] && (m_free[b] >= space_t'(e.len));
                cnt++;
                if (elig && (!find || (m_amt[b][e.port] > best_amt))) begin
                    best     = b;
                    best_amt = m_amt[b][e.port];
                end
                find = find | elig;
                if (find && (cnt >= lim)) begin
                    done = 1'b1;
                end
            end
        end
        e.exp_ok   = done;
        e.exp_sram = best;
        if (done) begin
            m_free[best]         = m_free[best] - space_t'(e.len);
            m_amt[best][e.port]  = m_amt[best][e.port] + 9'd1;
            m_last_valid         = 1'b1;
            m_last_sram          = best;
            m_last_port          = e.port;
        end
    endtask

    // ************************************************************
    // stimulus table
    // ************************************************************
    task automatic add_entry(input match_mode_t mode, input logic [4:0] thr,
                             input logic [NUM_SRAM-1:0] occ, input port_idx_t port,
                             input len_t len, input logic dup);
        entry_t e;
        e      = '0;
        e.mode = mode;
        e.thr  = thr;
        e.occ  = occ;
        e.port = port;
        e.len  = len;
        e.dup  = dup;
        tests[n_tests] = e;
        n_tests++;
    endtask

    // attaches a release to the entry added last
    task automatic add_release(input sram_idx_t b, input port_idx_t port, input len_t len);
        tests[n_tests-1].rel      = 1'b1;
        tests[n_tests-1].rel_sram = b;
        tests[n_tests-1].rel_port = port;
        tests[n_tests-1].rel_len  = len;
    endtask

    task automatic build_table();
        logic [NUM_SRAM-1:0] fill_free;
        fill_free = ~(32'h1 << (PORT_IDX + 1));
        add_entry(MODE_STATIC, 5'd0, '0, 4'd1, 9'd100, 1'b0);
        add_entry(MODE_STATIC, 5'd5, '0, 4'd1, 9'd50, 1'b1);
        add_entry(MODE_STATIC, 5'd1, 32'h1 << PORT_IDX, 4'd2, 9'd10, 1'b0);
        // build up packet counts for port 5 in banks 20 and 24
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 20), 4'd5, 9'd30, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 20), 4'd6, 9'd30, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 24), 4'd5, 9'd30, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 20), 4'd7, 9'd30, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 20), 4'd5, 9'd30, 1'b0);
        add_entry(MODE_STATIC, 5'd0, '0, 4'd0, 9'd10, 1'b0);
        add_entry(MODE_SEMI, 5'd17, '0, 4'd5, 9'd40, 1'b0);
        // nearly fill the bank after PORT_IDX
        add_entry(MODE_DYNAMIC, 5'd0, fill_free, 4'd10, 9'd500, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, fill_free, 4'd11, 9'd500, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, fill_free, 4'd10, 9'd500, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, fill_free, 4'd11, 9'd500, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, 32'h1 << PORT_IDX, 4'd12, 9'd100, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, fill_free, 4'd13, 9'd40, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd0, '0, 4'd13, 9'd20, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 17), 4'd14, 9'd10, 1'b0);
        add_entry(MODE_DYNAMIC, 5'd31, ~(32'h1 << 18), 4'd14, 9'd10, 1'b0);
        add_entry(MODE_STATIC, 5'd0, '0, 4'd0, 9'd8, 1'b0);
        add_entry(MODE_SEMI, 5'd17, '0, 4'd14, 9'd10, 1'b0);
        add_release(5'd17, 4'd14, 9'd10);
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            add_entry((i == 3) ? MODE_SEMI : MODE_DYNAMIC, rng[4:0], xorshift(rng),
                      rng[8:5], rng[20:12], 1'b0);
            rng = xorshift(rng);
        end
        for (int t = 0; t < n_tests; t++) begin
            predict(tests[t]);
        end
    endtask

    // ************************************************************
    // compare tasks
    // ************************************************************
    task automatic check_sram(input string name, input sram_idx_t got, input sram_idx_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ok(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        entry_t e;
        int     lat;
        int     ends_before;
        int     errs_before;
        e           = tests[t];
        ends_before = end_cnt;
        errs_before = errors;
        if (e.rel) begin
            @(posedge clk);
            release_valid <= 1'b1;
            release_sram  <= e.rel_sram;
            release_port  <= e.rel_port;
            release_len   <= e.rel_len;
            @(posedge clk);
            release_valid <= 1'b0;
        end
        @(posedge clk);
        match_mode <= e.mode;
        threshold  <= e.thr;
        occupied   <= e.occ;
        dest_port  <= e.port;
        length     <= e.len;
        req        <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        lat = 1;
        @(negedge clk);
        check_ok("busy", busy, 1'b1);
        while (!match_end && lat < MAX_CYCLES) begin
            @(posedge clk);
            lat++;
            // a second req lands while busy is high
            req <= e.dup && (lat == 2);
            @(negedge clk);
        end
        if (!match_end) begin
            $display("test %0d: match_end never arrived", t);
            errors++;
        end else begin
            check_ok("match_ok", match_ok, e.exp_ok);
            if (e.exp_ok) begin
                check_sram("matched_sram", matched_sram, e.exp_sram);
            end
            if (e.exp_fast) begin
                check_latency("latency", lat, 3);
            end
            @(negedge clk);
            check_ok("busy", busy, 1'b0);
        end
        repeat (8) @(posedge clk);
        if (end_cnt - ends_before != 1) begin
            $display("test %0d: saw %0d match_end pulses instead of one", t,
                     end_cnt - ends_before);
            errors++;
        end
        $display("test %0d %s: mode %0d port %0d len %0d ok %0b bank %0d latency %0d", t,
                 (errors == errs_before) ? "ok" : "bad", e.mode, e.port, e.len,
                 e.exp_ok, e.exp_sram, lat);
    endtask

    initial begin
        rst_n         = 1'b0;
        req           = 1'b0;
        dest_port     = '0;
        length        = '0;
        match_mode    = MODE_STATIC;
        threshold     = '0;
        occupied      = '0;
        release_valid = 1'b0;
        release_sram  = '0;
        release_port  = '0;
        release_len   = '0;
        n_tests       = 0;
        errors        = 0;
        checks        = 0;
        end_cnt       = 0;
        rng           = 32'h4213ec2e;
        m_last_valid  = 1'b0;
        m_last_sram   = '0;
        m_last_port   = '0;
        for (int b = 0; b < NUM_SRAM; b++) begin
            m_free[b] = SPACE_INIT;
            for (int p = 0; p < NUM_PORT; p++) begin
                m_amt[b][p] = '0;
            end
        end
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/sram_alloc_pkg.sv
verilog/sram_scan_if.sv
verilog/sram_scan_sequencer.sv
verilog/sram_status_table.sv
verilog/sram_best_picker.sv
verilog/port_wr_alloc.sv
dv/tb_port_wr_alloc.sv

/* run_sim.sh */
#!/bin/sh
# compiles the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -f compile.f --top-module tb_port_wr_alloc -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
